/* flist.f */
+incdir+.
items_pkg.sv
frame_tracker.sv
item_mask_gen.sv
pipe_reg.sv
items_vld_top.sv
tb_items_vld.sv

/* Makefile */
TOP := tb_items_vld

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

lint:
	verilator --lint-only --timing --assert -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* tb_items_vld.sv */
/*
 * Testbench for the item extractor. Sends directed and random frames,
 * predicts every output word from the offset and length rule, and
 * checks tx, the handshakes and the latency with concurrent assertions.
 */
`include "items_defines.svh"

module tb_items_vld;
    import items_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int DIR_FRAMES      = 5;
    localparam int RAND_FRAMES     = 60;
    localparam int WATCHDOG_CYCLES = 200 * (DIR_FRAMES + RAND_FRAMES) + 1000;

    logic       clk = 1'b0;
    logic       arst_n;
    rx_word_t   rx;
    logic       rx_src_rdy;
    logic       rx_dst_rdy;
    item_word_t tx;
    logic       tx_src_rdy;
    logic       tx_dst_rdy;

    integer     seed = 34;
    logic       src_gaps;     // Idle cycles between rx words.
    logic       sink_rand;    // Random tx back-pressure.
    item_word_t pending_exp;  // Expected output for the word on rx.

    // Reference queue owned by the monitor block.
    item_word_t exp_q[$];
    item_word_t exp_head;
    logic       exp_avail;
    logic       seen_accept;
    logic       acc_p1;
    logic       acc_p2;
    logic       rdy_p1;
    int         rx_count;

    logic       rx_accept;
    logic       tx_hs;

    assign rx_accept = rx_src_rdy && rx_dst_rdy;
    assign tx_hs     = tx_src_rdy && tx_dst_rdy;

    always #(CLK_PERIOD / 2) clk = ~clk;

    items_vld_top u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .rx         (rx),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx         (tx),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic items_meta_t make_meta(input int offset, input int length,
                                              input bit enable);
        items_meta_t m;
        m.offset = 8'(offset);
        m.length = 8'(length);
        m.enable = enable;
        return m;
    endfunction

    // Items from offset up to offset plus length, cut at eof_pos.
    function automatic item_word_t expected_item(input rx_word_t w, input int widx,
                                                 input items_meta_t m);
        item_word_t e;
        int         fidx;
        int         lo;
        int         hi;
        e.data     = w.data;
        e.vld_mask = '0;
        e.end_mask = '0;
        lo = int'(m.offset);
        hi = lo + int'(m.length);
        for (int i = 0; i < `ITEMS; i++) begin
            fidx = widx * `ITEMS + i;
            if (m.enable && fidx >= lo && fidx < hi && (!w.eof || i <= int'(w.eof_pos))) begin
                e.vld_mask[i] = 1'b1;
                if (fidx == hi - 1) begin
                    e.end_mask[i] = 1'b1;
                end
            end
        end
        return e;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
        tx_dst_rdy = sink_rand ? ({$random(seed)} % 3 != 0) : 1'b1;
    endtask

    task automatic send_word(input rx_word_t w);
        int target;
        while (src_gaps && ({$random(seed)} % 3 == 0)) begin
            rx_src_rdy = 1'b0;
            step();
        end
        rx         = w;
        rx_src_rdy = 1'b1;
        target     = rx_count + 1;
        while (rx_count < target) begin
            step();
        end
    endtask

    task automatic send_frame(input int n_words, input int last_pos, input items_meta_t meta);
        rx_word_t w;
        for (int k = 0; k < n_words; k++) begin
            w.data    = {$random(seed), $random(seed)};
            w.sof     = (k == 0);
            w.eof     = (k == n_words - 1);
            w.eof_pos = w.eof ? 3'(last_pos) : 3'($random(seed));
            // Later words carry junk meta that must not be used.
            w.meta    = w.sof ? meta : make_meta($random(seed), $random(seed), 1'($random(seed)));
            pending_exp = expected_item(w, k, meta);
            send_word(w);
        end
    endtask

    task automatic send_random_frame();
        int          n_words;
        int          last_pos;
        int          offset;
        int          length;
        items_meta_t meta;
        n_words  = 1 + {$random(seed)} % 6;
        last_pos = {$random(seed)} % `ITEMS;
        offset   = ({$random(seed)} % 4 == 0) ? {$random(seed)} % 256 : {$random(seed)} % 48;
        length   = ({$random(seed)} % 4 == 0) ? {$random(seed)} % 256 : {$random(seed)} % 32;
        meta     = make_meta(offset, length, {$random(seed)} % 4 != 0);
        send_frame(n_words, last_pos, meta);
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q.delete();
            exp_head    <= '0;
            exp_avail   <= 1'b0;
            seen_accept <= 1'b0;
            acc_p1      <= 1'b0;
            acc_p2      <= 1'b0;
            rdy_p1      <= 1'b0;
            rx_count = 0;
        end else begin
            if (tx_hs && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (rx_accept) begin
                exp_q.push_back(pending_exp);
                rx_count++;
            end
            exp_head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
            exp_avail   <= (exp_q.size() != 0);
            seen_accept <= seen_accept || rx_accept;
            acc_p1      <= rx_accept;
            acc_p2      <= acc_p1;
            rdy_p1      <= tx_dst_rdy;
        end
    end

    a_no_early_tx: assert property (@(posedge clk) disable iff (!arst_n)
        !seen_accept |-> !tx_src_rdy)
        else begin
            $display("CHECK FAILED tx_src_rdy got %h expected %h", $sampled(tx_src_rdy), 1'b0);
            stop_with_failure();
        end

    a_ready_empty: assert property (@(posedge clk) disable iff (!arst_n)
        !seen_accept |-> rx_dst_rdy)
        else begin
            $display("CHECK FAILED rx_dst_rdy got %h expected %h", $sampled(rx_dst_rdy), 1'b1);
            stop_with_failure();
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!arst_n)
        tx_hs |-> exp_avail)
        else begin
            $display("A word left tx while no word was expected.");
            stop_with_failure();
        end

    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        tx_hs |-> tx.data == exp_head.data)
        else begin
            $display("CHECK FAILED tx.data got %h expected %h",
                     $sampled(tx.data), $sampled(exp_head.data));
            stop_with_failure();
        end

    a_vld_mask: assert property (@(posedge clk) disable iff (!arst_n)
        tx_hs |-> tx.vld_mask == exp_head.vld_mask)
        else begin
            $display("CHECK FAILED tx.vld_mask got %h expected %h",
                     $sampled(tx.vld_mask), $sampled(exp_head.vld_mask));
            stop_with_failure();
        end

    a_end_mask: assert property (@(posedge clk) disable iff (!arst_n)
        tx_hs |-> tx.end_mask == exp_head.end_mask)
        else begin
            $display("CHECK FAILED tx.end_mask got %h expected %h",
                     $sampled(tx.end_mask), $sampled(exp_head.end_mask));
            stop_with_failure();
        end

    // Accepted two edges back with a free sink in between.
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        acc_p2 && rdy_p1 |-> tx_src_rdy)
        else begin
            $display("CHECK FAILED tx_src_rdy got %h expected %h", $sampled(tx_src_rdy), 1'b1);
            stop_with_failure();
        end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the test did not finish in time.");
        stop_with_failure();
    end

    initial begin
        arst_n      = 1'b0;
        rx          = '0;
        rx_src_rdy  = 1'b0;
        tx_dst_rdy  = 1'b1;
        pending_exp = '0;
        src_gaps    = 1'b0;
        sink_rand   = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        repeat (3) step();

        // Continuous stream with a free sink.
        send_frame(3, 7, make_meta(5, 14, 1'b1));   // Crosses two word boundaries.
        send_frame(2, 3, make_meta(10, 20, 1'b1));  // Runs past eof.
        send_frame(1, 7, make_meta(2, 3, 1'b0));    // Disabled.
        send_frame(1, 5, make_meta(0, 6, 1'b1));    // Ends on eof_pos.
        send_frame(4, 7, make_meta(8, 16, 1'b1));   // Exactly words 1 and 2.

        src_gaps  = 1'b1;
        sink_rand = 1'b1;
        repeat (RAND_FRAMES) send_random_frame();

        src_gaps   = 1'b0;
        sink_rand  = 1'b0;
        rx_src_rdy = 1'b0;
        while (exp_q.size() != 0) begin
            step();
        end
        step();

        $display("TB PASSED");
        $finish;
    end

endmodule

/* items_vld_top.sv */
/*
 * Top level of the item extractor. rx words pass frame tracking, a
 * register, mask generation and a second register before tx, which
 * gives two cycles of latency at one word per cycle.
 */
`include "items_defines.svh"

module items_vld_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  items_pkg::rx_word_t   rx,
    input  logic                  rx_src_rdy,
    output logic                  rx_dst_rdy,
    output items_pkg::item_word_t tx,
    output logic                  tx_src_rdy,
    input  logic                  tx_dst_rdy
);
    import items_pkg::*;

    tracked_word_t trk_in;
    tracked_word_t trk_q;
    logic          trk_vld;
    logic          out_rdy;  // Back-pressure from the output register.
    item_word_t    item;
    logic          rx_accept;

    assign rx_accept = rx_src_rdy && rx_dst_rdy;

    frame_tracker u_tracker (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .rx_accept (rx_accept),
        .trk       (trk_in)
    );

    pipe_reg #(.payload_t(tracked_word_t)) u_trk_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (trk_in),
        .in_valid  (rx_src_rdy),
        .in_ready  (rx_dst_rdy),
        .out_data  (trk_q),
        .out_valid (trk_vld),
        .out_ready (out_rdy)
    );

    item_mask_gen u_mask_gen (
        .trk  (trk_q),
        .item (item)
    );

    pipe_reg #(.payload_t(item_word_t)) u_out_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (item),
        .in_valid  (trk_vld),
        .in_ready  (out_rdy),
        .out_data  (tx),
        .out_valid (tx_src_rdy),
        .out_ready (tx_dst_rdy)
    );

endmodule

/* pipe_reg.sv */
/*
 * One-entry register slice with a src/dst ready handshake.
 * The payload type is a parameter, so one module serves every stage.
 */
`include "items_defines.svh"

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // Free when empty or when the held word leaves this cycle.
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

/* item_mask_gen.sv */
/*
 * Stage 2 of the extractor. Builds the per-item valid and end masks
 * from the word index, the frame metadata and eof_pos. Purely
 * combinational, the data passes through unchanged.
 */
`include "items_defines.svh"

module item_mask_gen (
    input  items_pkg::tracked_word_t trk,
    output items_pkg::item_word_t    item
);
    import items_pkg::*;

    // Wide enough for offset plus length and for any frame item index.
    localparam int IDX_W = `WIDX_W + `POS_W + 1;

    logic [IDX_W-1:0]  range_lo;
    logic [IDX_W-1:0]  range_hi;  // One past the last selected item.
    logic [IDX_W-1:0]  range_last;
    logic [IDX_W-1:0]  word_base;
    logic [`ITEMS-1:0] vld_bits;
    logic [`ITEMS-1:0] end_bits;

    assign range_lo   = IDX_W'(trk.meta.offset);
    assign range_hi   = IDX_W'(trk.meta.offset) + IDX_W'(trk.meta.length);
    assign range_last = range_hi - 1'b1;
    assign word_base  = IDX_W'(trk.word_idx) << `POS_W; // First item of this word.

    for (genvar i = 0; i < `ITEMS; i++) begin : g_item
        logic [IDX_W-1:0] idx;
        logic             in_frame;
        logic             in_range;

        assign idx      = word_base + IDX_W'(i);
        assign in_frame = !trk.eof || (`POS_W'(i) <= trk.eof_pos);
        assign in_range = (idx >= range_lo) && (idx < range_hi);

        assign vld_bits[i] = trk.meta.enable && in_frame && in_range;
        // A range cut short at eof has its last item invalid, so no mark.
        assign end_bits[i] = vld_bits[i] && (idx == range_last);
    end

    always_comb begin
        item.data     = trk.data;
        item.vld_mask = vld_bits;
        item.end_mask = end_bits;
    end

endmodule

/* frame_tracker.sv */
/*
 * Stage 1 of the extractor. Tracks the word index inside the current
 * frame and holds the metadata captured at sof, so that every word
 * leaves with its index and the frame's metadata attached.
 */
`include "items_defines.svh"

module frame_tracker (
    input  logic                     clk,
    input  logic                     arst_n,
    input  items_pkg::rx_word_t      rx,
    input  logic                     rx_accept,
    output items_pkg::tracked_word_t trk
);
    import items_pkg::*;

    logic [`WIDX_W-1:0] word_cnt;  // Index of the next non-sof word.
    logic [`WIDX_W-1:0] word_idx;
    items_meta_t        meta_q;

    // A sof word always starts the frame at index zero.
    assign word_idx = rx.sof ? '0 : word_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_cnt <= '0;
        end else if (rx_accept) begin
            if (rx.eof) begin
                word_cnt <= '0;
            end else if (word_idx != '1) begin
                word_cnt <= word_idx + 1'b1;
            end else begin
                word_cnt <= word_idx; // Saturate on very long frames.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_accept && rx.sof) begin
            meta_q <= rx.meta;
        end
    end

    always_comb begin
        trk.data     = rx.data;
        trk.eof      = rx.eof;
        trk.eof_pos  = rx.eof_pos;
        trk.word_idx = word_idx;
        // Held meta is not loaded yet on the sof word itself.
        trk.meta     = rx.sof ? rx.meta : meta_q;
    end

endmodule

/* items_pkg.sv */
/*
 * Struct types for the frame stream and the two pipeline stages.
 * Import into any module that handles rx, tracked or item words.
 */
`include "items_defines.svh"

package items_pkg;

    // Captured once per frame, at sof.
    typedef struct packed {
        logic [`OFFSET_W-1:0] offset;
        logic [`LENGTH_W-1:0] length;
        logic                 enable;
    } items_meta_t;

    // Input word as seen on rx.
    typedef struct packed {
        logic [`ITEMS*`ITEM_W-1:0] data;
        logic                      sof;
        logic                      eof;
        logic [`POS_W-1:0]         eof_pos;
        items_meta_t               meta;
    } rx_word_t;

    // Stage 1 output, meta is the value valid for the whole frame.
    typedef struct packed {
        logic [`ITEMS*`ITEM_W-1:0] data;
        logic                      eof;
        logic [`POS_W-1:0]         eof_pos;
        logic [`WIDX_W-1:0]        word_idx;
        items_meta_t               meta;
    } tracked_word_t;

    // Output word with per-item masks.
    typedef struct packed {
        logic [`ITEMS*`ITEM_W-1:0] data;
        logic [`ITEMS-1:0]         vld_mask;
        logic [`ITEMS-1:0]         end_mask; // Last selected item.
    } item_word_t;

endpackage

/* items_defines.svh */
/*
 * Sizing macros shared by the item extractor RTL and its testbench.
 * Include wherever word, item or metadata widths are needed.
 */
`ifndef ITEMS_DEFINES_SVH
`define ITEMS_DEFINES_SVH

// Word geometry.
`define ITEMS    8
`define ITEM_W   8

// Metadata fields carried at sof.
`define OFFSET_W 8
`define LENGTH_W 8

// Item position inside a word, log2 of ITEMS.
`define POS_W    3

// Word index inside a frame.
`define WIDX_W   6

`endif
